/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TB_TOP    ?= tb_board_top
RTL_TOP   ?= board_top
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(OBJ_DIR) -o sim_$(TB_TOP)
	@out="$$(./$(OBJ_DIR)/sim_$(TB_TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "^=== PASS ===$$"

clean:
	rm -rf $(OBJ_DIR)

/* common/board_macros.svh */
`ifndef BOARD_MACROS_SVH
`define BOARD_MACROS_SVH

//------------------------------------------------------------
// Board wiring

`define W_KEY      2     // Onboard push buttons, active low

//------------------------------------------------------------
// INMP441 I2S timing

`define SCK_DIV    4     // clk cycles per sck half period
`define WS_BITS    32    // sck periods per ws half

//------------------------------------------------------------
// TM1638 serial link

`define TM_DIV     4     // clk cycles per sio_clk half period
`define TM_GAP     64    // Idle clk cycles between frames

//------------------------------------------------------------
// Level meter scaling

`define BAR_SHIFT  20    // Magnitude to bar count

`endif

/* common/board_pkg.sv */
`default_nettype none

package board_pkg;

    //------------------------------------------------------------
    // Data widths

    typedef logic signed [23:0] sample_t;   // INMP441 word, two's complement
    typedef logic        [ 7:0] seg_t;      // abcdefgh, bit 7 is segment a
    typedef logic        [ 7:0] led_t;      // One bit per LED
    typedef logic        [ 7:0] key_t;      // One bit per key, 1 = pressed

    //------------------------------------------------------------
    // TM1638 frame sequencer

    typedef enum logic [2:0]
    {
        idle,                               // Only right after reset
        cmd_write,                          // 0x40, auto increment write
        addr,                               // 0xC0, start at display reg 0
        data,                               // 16 display bytes
        cmd_read,                           // 0x42, key scan read
        read_keys,                          // 4 key bytes from the module
        gap                                 // Quiet time before next frame
    } tm_state_t;

endpackage

`default_nettype wire

/* compile.f */
+incdir+common
common/board_pkg.sv
mic/i2s_mic_receiver.sv
src/key_merger.sv
src/level_meter.sv
tm1638/tm1638_board_controller.sv
src/board_top.sv
verification/tb_board_top.sv

/* mic/i2s_mic_receiver.sv */
`default_nettype none
`timescale 1ns/100ps

`include "board_macros.svh"

module i2s_mic_receiver
(
    input  wire                  clk,
    input  wire                  arst_n,
    output logic                 sck,
    output logic                 ws,
    input  wire                  sd,
    output board_pkg::sample_t   value,
    output logic                 value_valid
);

    localparam int DIV_W  = $clog2(`SCK_DIV);
    localparam int BIT_W  = $clog2(`WS_BITS) + 1;           // Counts both ws halves
    localparam int N_DATA = $bits(board_pkg::sample_t);

    logic [DIV_W-1:0]    div_cnt;
    logic [BIT_W-1:0]    bit_cnt;                           // sck period within the ws frame
    logic                sck_edge;
    logic                ws_q;
    logic                capture;
    board_pkg::sample_t  shift_q;

    assign sck_edge = div_cnt == DIV_W'(`SCK_DIV - 1);     // sck toggles here
    assign ws       = bit_cnt[BIT_W-1];                     // Low half = left channel

    // Rising sck, left half, bit 0 is the I2S delay slot
    assign capture  = sck_edge && !sck && !ws
                      && bit_cnt >= BIT_W'(1) && bit_cnt <= BIT_W'(N_DATA);

    //------------------------------------------------------------
    // Clock generation and word detect

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            div_cnt     <= '0;
            sck         <= 1'b0;
            bit_cnt     <= '0;
            ws_q        <= 1'b0;
            value_valid <= 1'b0;
        end
        else
        begin
            div_cnt <= sck_edge ? '0 : div_cnt + 1'b1;
            if (sck_edge)
            begin
                sck <= ~sck;
                if (sck)
                    bit_cnt <= bit_cnt + 1'b1;              // Next period on falling sck
            end
            ws_q        <= ws;
            value_valid <= ws && !ws_q;                     // Left word complete
        end
    end

    // Sample data path
    always_ff @(posedge clk)
    begin
        if (capture)
            shift_q <= {shift_q[N_DATA-2:0], sd};           // MSB first
        if (ws && !ws_q)
            value <= shift_q;
    end

    // One word per ws frame, so the strobe is a single cycle
    a_valid_pulse : assert property (
        @(posedge clk) disable iff (!arst_n) value_valid |=> !value_valid
    );

endmodule

`default_nettype wire

/* src/board_top.sv */
`default_nettype none
`timescale 1ns/100ps

`include "board_macros.svh"

module board_top
(
    input  wire               clk,
    input  wire               arst_n,
    input  wire  [`W_KEY-1:0] key,          // Onboard buttons, active low
    output board_pkg::led_t   led,          // Mirrors the level bar
    output wire               i2s_sck,
    output wire               i2s_ws,
    input  wire               i2s_sd,
    output wire               tm_sio_clk,
    output wire               tm_sio_stb,
    inout  wire               tm_sio_data
);

    board_pkg::sample_t value;
    logic               value_valid;
    board_pkg::seg_t    digit0;
    board_pkg::seg_t    digit1;
    board_pkg::key_t    tm_keys;
    logic               any_key;

    //------------------------------------------------------------
    // Microphone to level

    i2s_mic_receiver i_mic
    (
        .clk         ( clk         ),
        .arst_n      ( arst_n      ),
        .sck         ( i2s_sck     ),
        .ws          ( i2s_ws      ),
        .sd          ( i2s_sd      ),
        .value       ( value       ),
        .value_valid ( value_valid )
    );

    level_meter i_level
    (
        .clk         ( clk         ),
        .arst_n      ( arst_n      ),
        .value       ( value       ),
        .value_valid ( value_valid ),
        .clear       ( any_key     ),   // Any key drops the peak
        .bar         ( led         ),
        .digit0      ( digit0      ),
        .digit1      ( digit1      )
    );

    //------------------------------------------------------------
    // Keys and TM1638 module

    key_merger i_keys
    (
        .clk         ( clk         ),
        .arst_n      ( arst_n      ),
        .key         ( key         ),
        .tm_keys     ( tm_keys     ),
        .any_key     ( any_key     )
    );

    tm1638_board_controller i_tm
    (
        .clk         ( clk         ),
        .arst_n      ( arst_n      ),
        .digit0      ( digit0      ),
        .digit1      ( digit1      ),
        .led         ( led         ),   // Same bar on the module LEDs
        .keys        ( tm_keys     ),
        .sio_clk     ( tm_sio_clk  ),
        .sio_stb     ( tm_sio_stb  ),
        .sio_data    ( tm_sio_data )
    );

endmodule

`default_nettype wire

/* src/key_merger.sv */
`default_nettype none
`timescale 1ns/100ps

`include "board_macros.svh"

module key_merger
(
    input  wire                  clk,
    input  wire                  arst_n,
    input  wire  [`W_KEY-1:0]    key,           // Onboard buttons, active low
    input  wire  board_pkg::key_t tm_keys,      // From TM1638, already clk domain
    output logic                 any_key
);

    logic [`W_KEY-1:0] key_meta;                // First sync stage
    logic [`W_KEY-1:0] key_sync;                // 1 = pressed
    board_pkg::key_t   merged;
    logic              any_q;

    // Onboard keys land on the low bits, same as TM keys 0 and 1
    assign merged = tm_keys | board_pkg::key_t'(key_sync);

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            key_meta <= '0;
            key_sync <= '0;
            any_q    <= 1'b0;
            any_key  <= 1'b0;
        end
        else
        begin
            key_meta <= ~key;                   // Invert at the pin
            key_sync <= key_meta;
            any_q    <= |merged;
            any_key  <= any_q;                  // Two clk after merge
        end
    end

endmodule

`default_nettype wire

/* src/level_meter.sv */
`default_nettype none
`timescale 1ns/100ps

`include "board_macros.svh"

module level_meter
(
    input  wire                      clk,
    input  wire                      arst_n,
    input  wire  board_pkg::sample_t value,
    input  wire                      value_valid,
    input  wire                      clear,
    output board_pkg::led_t          bar,
    output board_pkg::seg_t          digit0,     // Peak high nibble
    output board_pkg::seg_t          digit1      // Peak low nibble
);

    logic [23:0]     neg;
    logic [22:0]     mag;                        // |value|, saturated
    logic [22:0]     shifted;
    logic [3:0]      count;                      // Lit LEDs, 0..8
    board_pkg::led_t bar_next;
    logic [7:0]      peak;
    logic [7:0]      cand;

    // Hex digit to abcdefgh, h (dot) always off
    function automatic board_pkg::seg_t hex_to_seg(input logic [3:0] nib);
        case (nib)
            4'h0: return 8'b1111_1100;
            4'h1: return 8'b0110_0000;
            4'h2: return 8'b1101_1010;
            4'h3: return 8'b1111_0010;
            4'h4: return 8'b0110_0110;
            4'h5: return 8'b1011_0110;
            4'h6: return 8'b1011_1110;
            4'h7: return 8'b1110_0000;
            4'h8: return 8'b1111_1110;
            4'h9: return 8'b1111_0110;
            4'ha: return 8'b1110_1110;
            4'hb: return 8'b0011_1110;
            4'hc: return 8'b1001_1100;
            4'hd: return 8'b0111_1010;
            4'he: return 8'b1001_1110;
            default: return 8'b1000_1110;        // F
        endcase
    endfunction

    always_comb
    begin
        neg = -value;
        if (value == 24'h80_0000)
            mag = '1;                            // -2^23 has no positive twin
        else if (value[23])
            mag = neg[22:0];
        else
            mag = value[22:0];

        shifted = mag >> `BAR_SHIFT;
        count   = (shifted > 23'd8) ? 4'd8 : shifted[3:0];
        for (int i = 0; i < 8; i++)
            bar_next[i] = count > 4'(i);         // Thermometer fill from bit 0

        cand = mag[22:15];
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            bar  <= '0;
            peak <= '0;
        end
        else
        begin
            if (value_valid)
                bar <= bar_next;
            if (clear)
                peak <= '0;                      // Clear beats a new maximum
            else if (value_valid && cand > peak)
                peak <= cand;
        end
    end

    assign digit0 = hex_to_seg(peak[7:4]);
    assign digit1 = hex_to_seg(peak[3:0]);

    a_bar_thermo : assert property (
        @(posedge clk) disable iff (!arst_n) (bar & (bar + 8'd1)) == 8'd0
    );

endmodule

`default_nettype wire

/* tm1638/tm1638_board_controller.sv */
`default_nettype none
`timescale 1ns/100ps

`include "board_macros.svh"

module tm1638_board_controller
(
    input  wire                  clk,
    input  wire                  arst_n,
    input  wire board_pkg::seg_t digit0,
    input  wire board_pkg::seg_t digit1,
    input  wire board_pkg::led_t led,
    output board_pkg::key_t      keys,
    output logic                 sio_clk,
    output logic                 sio_stb,
    inout  wire                  sio_data
);

    localparam int DIV_W = $clog2(`TM_DIV);
    localparam int GAP_W = $clog2(`TM_GAP);

    board_pkg::tm_state_t state;
    logic [DIV_W-1:0]     div_cnt;
    logic [GAP_W-1:0]     gap_cnt;
    logic                 tick;                 // One half period of sio_clk
    logic                 half;                 // 0 = falling next, 1 = rising next
    logic                 closing;              // Raise strobe on next tick
    logic [2:0]           bit_cnt;
    logic [3:0]           byte_cnt;
    logic [7:0]           tx;                   // Shifts out LSB first
    logic [7:0]           rx;
    logic [7:0]           rx_next;
    logic                 data_q;
    board_pkg::key_t      key_acc;

    // Display registers: even = digit segments, odd = LED in bit 0
    function automatic logic [7:0] data_byte(input logic [3:0] idx);
        if (idx[0])
            return {7'd0, led[idx[3:1]]};
        else if (idx[3:1] == 3'd0)
            return digit0;
        else if (idx[3:1] == 3'd1)
            return digit1;
        else
            return 8'h00;                       // Unused digits blank
    endfunction

    assign tick     = div_cnt == DIV_W'(`TM_DIV - 1);
    assign rx_next  = {sio_data, rx[7:1]};
    assign sio_data = (state == board_pkg::read_keys) ? 1'bz : data_q;  // Module drives keys

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state    <= board_pkg::idle;
            div_cnt  <= '0;
            gap_cnt  <= '0;
            half     <= 1'b0;
            closing  <= 1'b0;
            bit_cnt  <= '0;
            byte_cnt <= '0;
            tx       <= '0;
            rx       <= '0;
            data_q   <= 1'b1;
            key_acc  <= '0;
            keys     <= '0;
            sio_clk  <= 1'b1;
            sio_stb  <= 1'b1;
        end
        else
        begin
            div_cnt <= tick ? '0 : div_cnt + 1'b1;

            //------------------------------------------------------------
            // Inter-frame gap counts raw clocks
            if (state == board_pkg::gap)
            begin
                if (gap_cnt == GAP_W'(`TM_GAP - 1))
                begin
                    gap_cnt <= '0;
                    state   <= board_pkg::cmd_write;
                    tx      <= 8'h40;
                end
                else
                    gap_cnt <= gap_cnt + 1'b1;
            end
            else if (tick)
            begin
                if (closing)
                begin
                    sio_stb <= 1'b1;            // End of a strobe window
                    closing <= 1'b0;
                    case (state)
                        board_pkg::cmd_write:
                        begin
                            state <= board_pkg::addr;
                            tx    <= 8'hC0;
                        end
                        board_pkg::data:
                        begin
                            state <= board_pkg::cmd_read;
                            tx    <= 8'h42;
                        end
                        board_pkg::read_keys:
                        begin
                            state <= board_pkg::gap;
                            keys  <= key_acc;   // Frame ends here
                        end
                        default: state <= board_pkg::idle;
                    endcase
                end
                else if (state == board_pkg::idle)
                begin
                    state <= board_pkg::cmd_write;
                    tx    <= 8'h40;
                end
                else if (sio_stb)
                    sio_stb <= 1'b0;            // Strobe setup before first bit
                else if (!half)
                begin
                    sio_clk <= 1'b0;
                    data_q  <= tx[0];           // Data changes on falling clk
                    half    <= 1'b1;
                end
                else
                begin
                    sio_clk <= 1'b1;
                    half    <= 1'b0;
                    tx      <= tx >> 1;
                    bit_cnt <= bit_cnt + 1'b1;
                    if (state == board_pkg::read_keys)
                        rx <= rx_next;          // Sample on rising clk

                    //------------------------------------------------------------
                    // Byte boundary
                    if (bit_cnt == 3'd7)
                    begin
                        case (state)
                            board_pkg::cmd_write: closing <= 1'b1;
                            board_pkg::addr:
                            begin
                                state    <= board_pkg::data;
                                byte_cnt <= '0;
                                tx       <= data_byte(4'd0);
                            end
                            board_pkg::data:
                            begin
                                if (byte_cnt == 4'd15)
                                    closing <= 1'b1;
                                else
                                begin
                                    byte_cnt <= byte_cnt + 1'b1;
                                    tx       <= data_byte(byte_cnt + 4'd1);
                                end
                            end
                            board_pkg::cmd_read:
                            begin
                                state    <= board_pkg::read_keys;  // Release the line
                                byte_cnt <= '0;
                            end
                            board_pkg::read_keys:
                            begin
                                key_acc[{byte_cnt[1:0], 1'b0}] <= rx_next[0];
                                key_acc[{byte_cnt[1:0], 1'b1}] <= rx_next[4];
                                if (byte_cnt == 4'd3)
                                    closing <= 1'b1;
                                else
                                    byte_cnt <= byte_cnt + 1'b1;
                            end
                            default: ;
                        endcase
                    end
                end
            end
        end
    end

    // Clock only moves inside a strobe window
    a_clk_idle_high : assert property (
        @(posedge clk) disable iff (!arst_n) sio_stb |-> sio_clk
    );

endmodule

`default_nettype wire

/* verification/mic_trace.txt */
// Columns: sample (24 bit), TM keys, onboard keys pressed, expected bar, expected peak
// Onboard column is 1 = pressed, key lines carry a zero sample
000000 00 00 00 00
100000 00 00 01 20
350000 00 00 07 6A
F00000 00 00 01 6A
000000 01 00 00 00
280000 00 00 03 50
C00000 00 00 0F 80
000000 00 01 00 00
7FFFFF 00 00 7F FF
800000 00 00 7F FF
000000 80 00 00 00
0A0000 00 00 00 14
FE0000 00 00 00 14
000000 00 02 00 00
5AB000 00 00 1F B5
3C0000 00 00 07 B5

/* verification/tb_board_top.sv */
`default_nettype none
`timescale 1ns/100ps

`include "board_macros.svh"

module tb_board_top;

    localparam int N_LINES   = 16;
    localparam int WS_CLK    = 2 * `WS_BITS * 2 * `SCK_DIV;            // One ws period
    localparam int FRAME_CLK = (3 * 2 + 23 * 16) * `TM_DIV + `TM_GAP;  // Three windows of 23 bytes
    localparam int LIMIT     = N_LINES * (2 * WS_CLK + 8 * FRAME_CLK) + 10000;

    logic              clk = 1'b0;
    logic              arst_n;
    logic [`W_KEY-1:0] key;
    logic [7:0]        led;
    wire               i2s_sck;
    wire               i2s_ws;
    logic              i2s_sd;
    wire               tm_sio_clk;
    wire               tm_sio_stb;
    wire               tm_sio_data;

    logic [23:0] trace_mem [0:5*N_LINES-1];   // Five columns per line
    logic [23:0] cur_sample;                  // Sent on every left word
    logic [23:0] word;
    logic [7:0]  tm_pat;                      // Keys the module reports
    logic        drv_en;
    logic        drv_bit;
    logic        sck_prev;
    logic        ws_prev;
    logic        stb_prev;
    logic        sclk_prev;
    logic        sdata_prev;                  // Serial data level one step back
    int          bit_idx;
    int          ws_rises;
    int          cycles;
    int          errors;
    int          checks;

    // TM1638 model state
    int          win_bits;
    logic [7:0]  sh;
    logic [7:0]  cmd;
    logic [7:0]  cap [0:15];                  // Display bytes of the last frame
    logic [7:0]  first_bytes [0:1];
    int          first_cnt;
    int          data_start;
    int          data_done;
    int          read_done;

    assign tm_sio_data = drv_en ? drv_bit : 1'bz;   // Model drives only in key read

    always #20 clk = ~clk;                    // 40 ns period

    board_top board_top_inst
    (
        .clk         ( clk         ),
        .arst_n      ( arst_n      ),
        .key         ( key         ),
        .led         ( led         ),
        .i2s_sck     ( i2s_sck     ),
        .i2s_ws      ( i2s_ws      ),
        .i2s_sd      ( i2s_sd      ),
        .tm_sio_clk  ( tm_sio_clk  ),
        .tm_sio_stb  ( tm_sio_stb  ),
        .tm_sio_data ( tm_sio_data )
    );

    // Segment pattern back to its hex digit
    function automatic logic [3:0] seg_to_nibble(input logic [7:0] s);
        case (s)
            8'hFC: return 4'h0;
            8'h60: return 4'h1;
            8'hDA: return 4'h2;
            8'hF2: return 4'h3;
            8'h66: return 4'h4;
            8'hB6: return 4'h5;
            8'hBE: return 4'h6;
            8'hE0: return 4'h7;
            8'hFE: return 4'h8;
            8'hF6: return 4'h9;
            8'hEE: return 4'hA;
            8'h3E: return 4'hB;
            8'h9C: return 4'hC;
            8'h7A: return 4'hD;
            8'h9E: return 4'hE;
            8'h8E: return 4'hF;
            default: return 4'bxxxx;          // Not a digit pattern
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    //------------------------------------------------------------
    // One clk step with the I2S source and the TM1638 model
    task automatic advance_clk();
        logic [7:0] kb;
        int         k;
        @(posedge clk);
        #2;
        cycles++;

        // I2S source drives data after falling sck
        if (sck_prev && !i2s_sck)
        begin
            if (ws_prev && !i2s_ws)
            begin
                bit_idx = 0;                  // Left word starts with the delay slot
                word    = cur_sample;
            end
            else if (!i2s_ws)
                bit_idx++;
        end
        if (!ws_prev && i2s_ws)
            ws_rises++;
        i2s_sd = (!i2s_ws && bit_idx >= 1 && bit_idx <= 24) ? word[24-bit_idx] : 1'b0;

        // TM1638 window handling
        if (stb_prev && !tm_sio_stb)
        begin
            win_bits = 0;
            cmd      = 8'h00;
        end
        if (!tm_sio_stb && !sclk_prev && tm_sio_clk)
        begin
            if (!(cmd == 8'h42 && win_bits >= 8))
                sh = {sdata_prev, sh[7:1]};   // LSB first from the level before the edge
            win_bits++;
            if (win_bits % 8 == 0 && win_bits <= 8 * 17)
            begin
                k = win_bits / 8 - 1;
                if (k == 0)
                begin
                    cmd = sh;
                    if (first_cnt < 2)
                        first_bytes[first_cnt] = sh;
                    first_cnt++;
                    if (sh == 8'hC0)
                        data_start++;
                end
                else if (cmd == 8'hC0)
                    cap[k-1] = sh;
            end
            if (cmd == 8'h42 && win_bits == 40)
                drv_en = 1'b0;                // Last key bit taken
        end
        if (!tm_sio_stb && sclk_prev && !tm_sio_clk && cmd == 8'h42
            && win_bits >= 8 && win_bits < 40)
        begin
            k       = (win_bits - 8) / 8;
            kb      = {3'b000, tm_pat[2*k+1], 3'b000, tm_pat[2*k]};
            drv_en  = 1'b1;
            drv_bit = kb[(win_bits - 8) % 8];
        end
        if (!stb_prev && tm_sio_stb)
        begin
            if (cmd == 8'hC0)
                data_done++;
            if (cmd == 8'h42)
                read_done++;
            drv_en = 1'b0;
        end
        sck_prev   = i2s_sck;
        ws_prev    = i2s_ws;
        stb_prev   = tm_sio_stb;
        sclk_prev  = tm_sio_clk;
        sdata_prev = tm_sio_data;
    endtask

    task automatic wait_ws_rises(input int n);
        int target;
        target = ws_rises + n;
        while (ws_rises < target)
            advance_clk();
    endtask

    task automatic wait_key_reads(input int n);
        int target;
        target = read_done + n;
        while (read_done < target)
            advance_clk();
    endtask

    // Wait for a display frame that starts after now to complete
    task automatic wait_data_frame();
        int s0;
        s0 = data_start;
        while (data_start == s0)
            advance_clk();
        while (data_done < data_start)
            advance_clk();
    endtask

    //------------------------------------------------------------
    // Run limit
    initial
    begin
        wait (cycles > LIMIT);
        $display("Timeout: the DUT stopped making progress after %0d cycles", cycles);
        $display("=== FAIL ===");
        $finish;
    end

    initial
    begin
        int         ln;
        logic [7:0] exp_bar;
        logic [7:0] exp_peak;
        logic [7:0] on_pat;
        logic       key_line;
        arst_n = 1'b0;
        key = '1;                                 // Released keys read high
        i2s_sd = 1'b0;
        drv_en = 1'b0;
        drv_bit = 1'b0;
        cur_sample = '0;
        word = '0;
        tm_pat = '0;
        sck_prev = 1'b0;
        ws_prev = 1'b0;
        stb_prev = 1'b1;
        sclk_prev = 1'b1;
        sdata_prev = 1'b1;
        bit_idx = 0;
        ws_rises = 0;
        cycles = 0;
        errors = 0;
        checks = 0;
        win_bits = 0;
        sh = '0;
        cmd = '0;
        first_cnt = 0;
        data_start = 0;
        data_done = 0;
        read_done = 0;
        $readmemh("verification/mic_trace.txt", trace_mem);

        repeat (2) @(posedge clk);
        #2 arst_n = 1'b1;                         // Two cycles of reset
        advance_clk();
        check_value("reset led", 32'h0, 32'(led));
        check_value("reset strobe", 32'h1, 32'(tm_sio_stb));
        check_value("reset sio clk", 32'h1, 32'(tm_sio_clk));
        check_value("reset sck", 32'h0, 32'(i2s_sck));
        check_value("reset ws", 32'h0, 32'(i2s_ws));

        //------------------------------------------------------------
        // Trace lines
        for (ln = 0; ln < N_LINES; ln++)
        begin
            cur_sample = trace_mem[5*ln];
            tm_pat     = trace_mem[5*ln+1][7:0];
            on_pat     = trace_mem[5*ln+2][7:0];
            exp_bar    = trace_mem[5*ln+3][7:0];
            exp_peak   = trace_mem[5*ln+4][7:0];
            key_line   = (tm_pat != 8'h00) || (on_pat != 8'h00);
            key        = ~on_pat[`W_KEY-1:0];

            wait_ws_rises(2);                     // A whole word of this sample
            repeat (4) advance_clk();
            check_value($sformatf("bar line %0d", ln), 32'(exp_bar), 32'(led));

            if (key_line)
                wait_key_reads(2);                // Keys latched by the controller
            wait_data_frame();
            check_value($sformatf("peak line %0d", ln), 32'(exp_peak),
                        32'({seg_to_nibble(cap[0]), seg_to_nibble(cap[2])}));
            for (int i = 0; i < 8; i++)
                check_value($sformatf("led byte %0d line %0d", i, ln),
                            32'(exp_bar[i]), 32'(cap[2*i+1]));
            for (int i = 2; i < 8; i++)
                check_value($sformatf("blank digit %0d line %0d", i, ln),
                            32'h0, 32'(cap[2*i]));

            if (key_line)
            begin
                tm_pat = 8'h00;
                key    = '1;
                wait_key_reads(2);                // Controller keys back to 0
                repeat (4) advance_clk();
            end
        end

        check_value("first window byte", 32'h40, 32'(first_bytes[0]));
        check_value("second window byte", 32'hC0, 32'(first_bytes[1]));

        $display("Checks %0d, errors %0d, cycles %0d", checks, errors, cycles);
        if (errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire
